// ==== hdl/capture_pkg.sv ====
package capture_pkg;

    localparam int SAMPLE_W = 18;           // raw adc sample
    localparam int BYTE_W   = 8;            // byte mode sample

    // packer accumulator: up to 63 residual bits plus one full sample
    localparam int ACC_W = 64 + SAMPLE_W;
    localparam int CNT_W = 7;               // holds bit counts up to 81

    typedef enum logic {
        mode_18bit,
        mode_byte
    } pack_mode_e;

    // only changed while the capture is idle
    typedef struct packed {
        logic       enabled;
        pack_mode_e mode;
    } capture_cfg_t;

    typedef struct packed {
        logic [SAMPLE_W-1:0] data;          // low byte only in byte mode
    } sample_t;

endpackage

// ==== hdl/fifo_pkg.sv ====
package fifo_pkg;

    localparam int WORD_W     = 64;         // ddr word
    localparam int FIFO_AW    = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_AW;

    typedef struct packed {
        logic [WORD_W-1:0] data;
    } ddr_word_t;

    typedef enum logic [1:0] {
        drain_idle,
        drain_wait,                         // done seen, fifo still draining
        drain_pulse
    } drain_state_e;

endpackage

// ==== hdl/sample_packer.sv ====
`timescale 1ns/100ps

module sample_packer
    import capture_pkg::*, fifo_pkg::*;
(
    input  logic         wr_clk,
    input  logic         reset,
    input  capture_cfg_t cfg,
    input  logic         capture_start,
    input  sample_t      sample,
    input  logic         sample_wr,
    output ddr_word_t    word,
    output logic         word_wr
);

    logic [ACC_W-1:0] acc;                  // right-justified bit stream
    logic [CNT_W-1:0] bit_count;            // valid bits at the bottom of acc
    logic [ACC_W-1:0] acc_append;
    logic [ACC_W-1:0] acc_aligned;
    logic [CNT_W-1:0] add_bits;
    logic [CNT_W-1:0] sub_bits;
    logic             word_ready;

    always_comb begin
        word_ready = (bit_count >= CNT_W'(WORD_W));

        if (cfg.mode == mode_byte) begin
            acc_append = {acc[ACC_W-BYTE_W-1:0], sample.data[BYTE_W-1:0]};
            add_bits   = CNT_W'(BYTE_W);
        end else begin
            acc_append = {acc[ACC_W-SAMPLE_W-1:0], sample.data};
            add_bits   = CNT_W'(SAMPLE_W);
        end

        if (!sample_wr) begin
            add_bits = '0;
        end

        sub_bits = word_ready ? CNT_W'(WORD_W) : '0;

        // oldest 64 valid bits land at the bottom
        acc_aligned = acc >> (bit_count - CNT_W'(WORD_W));
    end

    // a complete word waits one edge in acc, then goes out with word_wr
    always_ff @(posedge wr_clk) begin
        if (reset) begin
            bit_count <= '0;
            word_wr   <= 1'b0;
        end else if (capture_start || !cfg.enabled) begin
            bit_count <= '0;                // drop the partial word
            word_wr   <= 1'b0;
        end else begin
            bit_count <= bit_count - sub_bits + add_bits;
            word_wr   <= word_ready;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (sample_wr) begin
            acc <= acc_append;
        end
        if (word_ready) begin
            word.data <= acc_aligned[WORD_W-1:0];   // earliest bit in data[63]
        end
    end

endmodule

// ==== hdl/cdc_pulse.sv ====
`timescale 1ns/100ps

module cdc_pulse (
    input  logic src_clk,
    input  logic dst_clk,
    input  logic reset,
    input  logic src_pulse,
    output logic dst_pulse
);

    logic       src_toggle;
    logic [2:0] dst_sync;                   // [0] is the metastable stage

    always_ff @(posedge src_clk) begin
        if (reset) begin
            src_toggle <= 1'b0;
        end else if (src_pulse) begin
            src_toggle <= ~src_toggle;
        end
    end

    always_ff @(posedge dst_clk) begin
        if (reset) begin
            dst_sync  <= '0;
            dst_pulse <= 1'b0;
        end else begin
            dst_sync  <= {dst_sync[1:0], src_toggle};
            dst_pulse <= dst_sync[2] ^ dst_sync[1];   // one cycle per toggle
        end
    end

endmodule

// ==== hdl/async_word_fifo.sv ====
`timescale 1ns/100ps

module async_word_fifo
    import fifo_pkg::*;
(
    input  logic      wr_clk,
    input  logic      rd_clk,
    input  logic      reset,
    input  logic      capture_start,
    input  ddr_word_t word,
    input  logic      word_wr,
    input  logic      fifo_rd,
    input  logic      fifo_flush,
    output ddr_word_t fifo_dout,
    output logic      fifo_empty,
    output logic      overflow
);

    ddr_word_t        mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_bin;
    logic [FIFO_AW:0] wr_gray;
    logic [FIFO_AW:0] rd_bin;
    logic [FIFO_AW:0] rd_gray;
    logic [FIFO_AW:0] rd_gray_s1;           // read pointer seen in wr_clk
    logic [FIFO_AW:0] rd_gray_s2;
    logic [FIFO_AW:0] wr_gray_s1;           // write pointer seen in rd_clk
    logic [FIFO_AW:0] wr_gray_s2;
    logic [FIFO_AW:0] wr_bin_next;
    logic [FIFO_AW:0] rd_bin_next;
    logic             full;
    logic             push;
    logic             pop;

    // full when the gray pointers differ only in the two top bits
    assign full = (wr_gray == {~rd_gray_s2[FIFO_AW:FIFO_AW-1], rd_gray_s2[FIFO_AW-2:0]});
    assign push = word_wr && !full;
    assign wr_bin_next = wr_bin + (FIFO_AW+1)'(1);

    always_ff @(posedge wr_clk) begin
        if (reset) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            if (push) begin
                wr_bin  <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem[wr_bin[FIFO_AW-1:0]] <= word;
        end
    end

    // sticky until the next capture
    always_ff @(posedge wr_clk) begin
        if (reset || capture_start) begin
            overflow <= 1'b0;
        end else if (word_wr && full) begin
            overflow <= 1'b1;
        end
    end

    assign fifo_empty  = (rd_gray == wr_gray_s2);
    assign pop         = (fifo_rd || fifo_flush) && !fifo_empty;
    assign rd_bin_next = rd_bin + (FIFO_AW+1)'(1);
    assign fifo_dout   = mem[rd_bin[FIFO_AW-1:0]];   // fall-through head

    always_ff @(posedge rd_clk) begin
        if (reset) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            if (pop) begin
                rd_bin  <= rd_bin_next;
                rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            end
        end
    end

endmodule

// ==== hdl/drain_tracker.sv ====
`timescale 1ns/100ps

module drain_tracker
    import fifo_pkg::*;
(
    input  logic rd_clk,
    input  logic reset,
    input  logic enabled,
    input  logic done_rd,
    input  logic fifo_empty,
    output logic capture_done_out
);

    drain_state_e state;
    logic         empty_r;                  // empty on the previous cycle

    always_ff @(posedge rd_clk) begin
        if (reset || !enabled) begin
            state   <= drain_idle;
            empty_r <= 1'b0;
        end else begin
            empty_r <= fifo_empty;
            case (state)
                drain_idle: begin
                    if (done_rd) begin
                        state <= drain_wait;
                    end
                end
                drain_wait: begin
                    if (fifo_empty && empty_r) begin
                        state <= drain_pulse;   // two empty cycles in a row
                    end
                end
                default: begin
                    state <= drain_idle;
                end
            endcase
        end
    end

    assign capture_done_out = (state == drain_pulse);

endmodule

// ==== hdl/capture_to_ddr_top.sv ====
`timescale 1ns/100ps

module capture_to_ddr_top
    import capture_pkg::*, fifo_pkg::*;
(
    input  logic         wr_clk,
    input  logic         rd_clk,
    input  logic         reset,
    input  capture_cfg_t cfg,
    input  logic         capture_start,
    input  logic         capture_done,
    input  sample_t      sample,
    input  logic         sample_wr,
    input  logic         fifo_rd,
    input  logic         fifo_flush,
    output ddr_word_t    fifo_dout,
    output logic         fifo_empty,
    output logic         capture_start_out,
    output logic         capture_done_out,
    output logic         overflow
);

    ddr_word_t word;
    logic      word_wr;
    logic      done_rd;                     // capture_done in rd_clk

    sample_packer u_sample_packer (
        .wr_clk        (wr_clk),
        .reset         (reset),
        .cfg           (cfg),
        .capture_start (capture_start),
        .sample        (sample),
        .sample_wr     (sample_wr),
        .word          (word),
        .word_wr       (word_wr)
    );

    async_word_fifo u_async_word_fifo (
        .wr_clk        (wr_clk),
        .rd_clk        (rd_clk),
        .reset         (reset),
        .capture_start (capture_start),
        .word          (word),
        .word_wr       (word_wr),
        .fifo_rd       (fifo_rd),
        .fifo_flush    (fifo_flush),
        .fifo_dout     (fifo_dout),
        .fifo_empty    (fifo_empty),
        .overflow      (overflow)
    );

    drain_tracker u_drain_tracker (
        .rd_clk           (rd_clk),
        .reset            (reset),
        .enabled          (cfg.enabled),
        .done_rd          (done_rd),
        .fifo_empty       (fifo_empty),
        .capture_done_out (capture_done_out)
    );

    cdc_pulse u_done_cdc (
        .src_clk   (wr_clk),
        .dst_clk   (rd_clk),
        .reset     (reset),
        .src_pulse (capture_done),
        .dst_pulse (done_rd)
    );

    cdc_pulse u_start_cdc (
        .src_clk   (wr_clk),
        .dst_clk   (rd_clk),
        .reset     (reset),
        .src_pulse (capture_start && cfg.enabled),   // only enabled starts count
        .dst_pulse (capture_start_out)
    );

endmodule

// ==== tb/ref_packer.svh ====
`ifndef REF_PACKER_SVH
`define REF_PACKER_SVH

typedef logic [SAMPLE_W-1:0] sample_q_t[$];
typedef logic [WORD_W-1:0]   word_q_t[$];

// bit stream model: oldest sample first, msb first, partial word dropped
function automatic word_q_t pack_reference(sample_q_t samples, pack_mode_e mode);
    word_q_t           words;
    logic [WORD_W-1:0] cur;
    int                nbits;
    int                width;
    int                b;
    words = {};
    cur   = '0;
    nbits = 0;
    width = (mode == mode_byte) ? BYTE_W : SAMPLE_W;
    foreach (samples[i]) begin
        for (b = width - 1; b >= 0; b--) begin
            cur = {cur[WORD_W-2:0], samples[i][b]};
            nbits++;
            if (nbits == WORD_W) begin
                words.push_back(cur);
                nbits = 0;
            end
        end
    end
    return words;
endfunction

`endif

// ==== tb/tb_capture_to_ddr.sv ====
`timescale 1ns/100ps

module tb_capture_to_ddr
    import capture_pkg::*, fifo_pkg::*;
();

    `include "ref_packer.svh"

    logic         wr_clk = 1'b0;
    logic         rd_clk = 1'b0;
    logic         reset;
    capture_cfg_t cfg;
    logic         capture_start;
    logic         capture_done;
    sample_t      sample;
    logic         sample_wr;
    logic         fifo_rd;
    logic         fifo_flush;
    ddr_word_t    fifo_dout;
    logic         fifo_empty;
    logic         capture_start_out;
    logic         capture_done_out;
    logic         overflow;

    sample_q_t gen_q;                       // samples of the current burst
    word_q_t   exp_q;                       // words still to be read
    logic      rd_enable;
    logic      done_seen;
    int        start_count;
    int        done_count;
    int        words_read;

    always #2 rd_clk = ~rd_clk;
    always #3 wr_clk = ~wr_clk;

    capture_to_ddr_top u_capture_to_ddr_top (.*);

    task automatic fail_now();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic value_error(string msg);
        $display("ERR %0t ns: %s", $time, msg);
        fail_now();
    endtask

    task automatic stop_run(string msg);
        $display("%s", msg);
        fail_now();
    endtask

    // consumer: pops the head whenever one is visible
    always @(negedge rd_clk) begin : reader
        logic [WORD_W-1:0] expected;
        if (!reset && rd_enable && !fifo_empty) begin
            assert (!done_seen) else stop_run("a word was read after capture_done_out");
            assert (exp_q.size() > 0) else stop_run("a word was read but none was expected");
            expected = exp_q.pop_front();
            assert (fifo_dout.data === expected)
                else value_error($sformatf("word %0d is %h, expected %h",
                                           words_read, fifo_dout.data, expected));
            words_read++;
            fifo_rd = 1'b1;
        end else begin
            fifo_rd = 1'b0;
        end
    end

    always @(negedge rd_clk) begin : pulse_monitor
        if (capture_start_out) begin
            start_count++;
        end
        if (capture_done_out) begin
            assert (exp_q.size() == 0)
                else stop_run("capture_done_out came before all words were read");
            done_count++;
            done_seen = 1'b1;
        end
    end

    task automatic gen_samples(int n);
        gen_q = {};
        repeat (n) gen_q.push_back(SAMPLE_W'($urandom()));
    endtask

    task automatic drive_samples();
        foreach (gen_q[i]) begin
            @(negedge wr_clk);
            sample.data = gen_q[i];
            sample_wr   = 1'b1;
        end
        @(negedge wr_clk);
        sample_wr = 1'b0;
        repeat (4) @(negedge wr_clk);       // let the last word leave the packer
    endtask

    task automatic pulse_start();
        @(negedge wr_clk);
        capture_start = 1'b1;
        @(negedge wr_clk);
        capture_start = 1'b0;
        repeat (2) @(negedge wr_clk);
    endtask

    task automatic wait_drained(string what);
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            @(negedge rd_clk);
            t++;
            if (t > 3000) stop_run($sformatf("timeout while waiting for %s", what));
        end
    endtask

    initial begin
        word_q_t ref_words;
        int      t;
        void'($urandom(32'h872c));
        reset = 1'b1;
        {capture_start, capture_done, sample_wr, fifo_flush, fifo_rd} = '0;
        cfg         = '{enabled: 1'b0, mode: mode_18bit};
        sample      = '0;
        rd_enable   = 1'b1;
        done_seen   = 1'b0;
        start_count = 0;
        done_count  = 0;
        words_read  = 0;
        repeat (5) @(negedge rd_clk);
        reset = 1'b0;
        assert (fifo_empty && !overflow) else stop_run("outputs not idle after reset");
        @(negedge wr_clk);
        cfg.enabled = 1'b1;

        // 18-bit mode, 64 samples give 18 words
        pulse_start();
        gen_samples(64);
        exp_q = pack_reference(gen_q, mode_18bit);
        assert (exp_q.size() == 18) else stop_run("reference gave the wrong word count");
        drive_samples();
        wait_drained("the 18-bit mode words");

        // byte mode, 40 samples give 5 words
        @(negedge wr_clk);
        cfg.mode = mode_byte;
        pulse_start();
        gen_samples(40);
        exp_q = pack_reference(gen_q, mode_byte);
        drive_samples();
        wait_drained("the byte mode words");

        // restart in the middle of a word
        @(negedge wr_clk);
        cfg.mode = mode_18bit;
        pulse_start();
        gen_samples(20);
        exp_q = pack_reference(gen_q, mode_18bit);
        drive_samples();
        start_count = 0;
        pulse_start();
        gen_samples(32);
        ref_words = pack_reference(gen_q, mode_18bit);
        foreach (ref_words[i]) exp_q.push_back(ref_words[i]);
        drive_samples();
        wait_drained("the words after the restart");
        t = 0;
        while (start_count == 0) begin
            @(negedge rd_clk);
            t++;
            if (t > 100) stop_run("timeout while waiting for capture_start_out");
        end
        repeat (10) @(negedge rd_clk);
        assert (start_count == 1) else stop_run("capture_start_out pulsed more than once");

        // done only after the last word has been read
        done_count = 0;
        @(negedge rd_clk);
        rd_enable = 1'b0;                   // words still queued when done arrives
        gen_samples(32);
        exp_q = pack_reference(gen_q, mode_18bit);
        drive_samples();
        @(negedge wr_clk);
        capture_done = 1'b1;
        @(negedge wr_clk);
        capture_done = 1'b0;
        @(negedge rd_clk);
        rd_enable = 1'b1;
        t = 0;
        while (done_count == 0) begin
            @(negedge rd_clk);
            t++;
            if (t > 100) stop_run("timeout while waiting for capture_done_out");
        end
        repeat (20) @(negedge rd_clk);
        assert (done_count == 1) else stop_run("capture_done_out pulsed more than once");
        done_seen = 1'b0;

        // overflow with reads held off, then flush
        @(negedge wr_clk);
        cfg.mode = mode_byte;
        pulse_start();
        @(negedge rd_clk);
        rd_enable = 1'b0;
        gen_samples(160);
        ref_words = pack_reference(gen_q, mode_byte);
        for (int i = 0; i < FIFO_DEPTH; i++) exp_q.push_back(ref_words[i]);
        drive_samples();
        t = 0;
        while (!overflow) begin
            @(negedge wr_clk);
            t++;
            if (t > 100) stop_run("timeout while waiting for overflow");
        end
        @(negedge rd_clk);
        rd_enable = 1'b1;
        wait_drained("the words kept in the full FIFO");
        @(negedge rd_clk);
        rd_enable = 1'b0;
        gen_samples(32);
        drive_samples();
        @(negedge rd_clk);
        assert (!fifo_empty) else stop_run("no words in the FIFO before the flush");
        fifo_flush = 1'b1;
        t = 0;
        for (int quiet = 0; quiet < 10; ) begin
            @(negedge rd_clk);
            quiet = fifo_empty ? quiet + 1 : 0;
            t++;
            if (t > 200) stop_run("timeout while flushing the FIFO");
        end
        fifo_flush = 1'b0;
        @(negedge rd_clk);
        assert (fifo_empty) else stop_run("FIFO not empty after the flush");
        assert (overflow) else stop_run("overflow did not stay set until the next start");
        pulse_start();
        assert (!overflow) else stop_run("capture_start did not clear overflow");

        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #200000;
        stop_run("global simulation time limit reached");
    end

endmodule

// ==== sources.f ====
+incdir+tb
hdl/capture_pkg.sv
hdl/fifo_pkg.sv
hdl/sample_packer.sv
hdl/cdc_pulse.sv
hdl/async_word_fifo.sv
hdl/drain_tracker.sv
hdl/capture_to_ddr_top.sv
tb/tb_capture_to_ddr.sv

// ==== Makefile ====
TOP = tb_capture_to_ddr

.PHONY: build run clean

build:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
